//--- rtl/cache_pkg.sv
// cache geometry, RAM timing, controller state enum and RAM fill pattern
package cache_pkg;

  // datapath word and address width
  localparam int WORD_W = 32;

  // two ways of eight sets, two words per block
  localparam int SETS  = 8;
  localparam int IDX_W = 3;
  localparam int TAG_W = 26;  // addr[31:6]

  // data RAM size, in words
  localparam int RAM_WORDS = 64;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  // wait cycles before each RAM access completes
  localparam int RAM_LAT = 2;
  localparam int CNT_W   = $clog2(RAM_LAT + 1);

  // RAM word at byte address A resets to A ^ FILL_KEY
  localparam logic [WORD_W-1:0] FILL_KEY = 32'hC0DE_5EED;

  typedef enum logic [3:0] {
    IDLE,        // serve hits, start misses and flush
    FETCH0,      // fill word 0 of the block
    FETCH1,      // fill word 1, then back to IDLE
    EVICT0,      // write back word 0 of a dirty victim
    EVICT1,
    FLUSH_SCAN,  // look at one line per cycle
    FLUSH_WB0,   // write back a dirty line found by the scan
    FLUSH_WB1,
    FLUSHED      // all lines clean and invalid, wait for halt to drop
  } cache_state_t;

endpackage

//--- rtl/ram_ctrl.sv
// word-addressed data RAM with a fixed wait-state counter and reset fill pattern
`timescale 1ns/100ps

module ram_ctrl (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        mem_ren,
  input  logic                        mem_wen,
  input  logic [cache_pkg::WORD_W-1:0] mem_addr,
  input  logic [cache_pkg::WORD_W-1:0] mem_store,
  output logic [cache_pkg::WORD_W-1:0] mem_load,
  output logic                        mem_wait
);

  logic [cache_pkg::WORD_W-1:0] ram [cache_pkg::RAM_WORDS];
  logic [cache_pkg::CNT_W-1:0]  wait_cnt;  // cycles waited on the current word
  logic [cache_pkg::RAM_AW-1:0] widx;
  logic                         access;

  assign access = mem_ren || mem_wen;
  assign widx   = mem_addr[cache_pkg::RAM_AW+1:2];  // byte address wraps at 256

  // wait until RAM_LAT cycles have passed, release for exactly one cycle
  assign mem_wait = access && (wait_cnt != cache_pkg::CNT_W'(cache_pkg::RAM_LAT));
  assign mem_load = ram[widx];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (mem_wait) begin
      wait_cnt <= wait_cnt + 1'b1;
    end else begin
      wait_cnt <= '0;  // done or idle, next word starts over
    end
  end

  // contents
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < cache_pkg::RAM_WORDS; i++) begin
        ram[i] <= (cache_pkg::WORD_W'(i) << 2) ^ cache_pkg::FILL_KEY;
      end
    end else if (mem_wen && !mem_wait) begin
      ram[widx] <= mem_store;
    end
  end

endmodule

//--- rtl/dcache.sv
// two-way write-back data cache controller with LRU, miss fill, eviction and halt flush
`timescale 1ns/100ps

module dcache (
  input  logic                        CLK,
  input  logic                        nRST,
  // datapath side
  input  logic                        dmemren,
  input  logic                        dmemwen,
  input  logic                        halt,
  input  logic [cache_pkg::WORD_W-1:0] dmemaddr,
  input  logic [cache_pkg::WORD_W-1:0] dmemstore,
  output logic [cache_pkg::WORD_W-1:0] dmemload,
  output logic                        dhit,
  output logic                        flushed,
  // memory side
  output logic                        mem_ren,
  output logic                        mem_wen,
  output logic [cache_pkg::WORD_W-1:0] mem_addr,
  output logic [cache_pkg::WORD_W-1:0] mem_store,
  input  logic [cache_pkg::WORD_W-1:0] mem_load,
  input  logic                        mem_wait
);

  // line storage, indexed [way][set]
  logic [cache_pkg::TAG_W-1:0]  tags  [2][cache_pkg::SETS];
  logic [cache_pkg::WORD_W-1:0] data  [2][cache_pkg::SETS][2];
  logic [cache_pkg::SETS-1:0]   valid [2];
  logic [cache_pkg::SETS-1:0]   dirty [2];
  logic [cache_pkg::SETS-1:0]   lru;  // way to replace next

  cache_pkg::cache_state_t state;
  cache_pkg::cache_state_t state_nxt;

  logic [cache_pkg::IDX_W-1:0] count;  // flush set pointer
  logic                        fl_way;  // flush way pointer

  // request decode
  logic [cache_pkg::TAG_W-1:0] req_tag;
  logic [cache_pkg::IDX_W-1:0] req_idx;
  logic                        req_off;
  logic                        req;
  logic                        hit0;
  logic                        hit1;
  logic                        victim;
  logic                        victim_dirty;

  // flush scan
  logic line_dirty;
  logic set_last;
  logic scan_last;
  logic flush_st;

  // write-back and fetch line selection
  logic                        wb_way;
  logic [cache_pkg::IDX_W-1:0] wb_idx;
  logic                        wb_word;
  logic                        fetch_word;

  // update strobes from the FSM
  logic acc_hit;
  logic wr_hit;
  logic fill_we;
  logic fill_last;
  logic fl_start;
  logic fl_adv;

  assign req_tag = dmemaddr[cache_pkg::WORD_W-1 -: cache_pkg::TAG_W];
  assign req_idx = dmemaddr[5:3];
  assign req_off = dmemaddr[2];
  assign req     = dmemren || dmemwen;

  assign hit0 = valid[0][req_idx] && (tags[0][req_idx] == req_tag);
  assign hit1 = valid[1][req_idx] && (tags[1][req_idx] == req_tag);

  assign victim       = lru[req_idx];
  assign victim_dirty = valid[victim][req_idx] && dirty[victim][req_idx];

  assign line_dirty = valid[fl_way][count] && dirty[fl_way][count];
  assign set_last   = (count == cache_pkg::IDX_W'(cache_pkg::SETS - 1));
  assign scan_last  = fl_way && set_last;  // way 1 is scanned last

  assign flush_st = (state == cache_pkg::FLUSH_SCAN) || (state == cache_pkg::FLUSH_WB0) ||
                    (state == cache_pkg::FLUSH_WB1);

  assign wb_way     = flush_st ? fl_way : victim;
  assign wb_idx     = flush_st ? count : req_idx;
  assign wb_word    = (state == cache_pkg::EVICT1) || (state == cache_pkg::FLUSH_WB1);
  assign fetch_word = (state == cache_pkg::FETCH1);

  assign dmemload = data[hit1][req_idx][req_off];  // way 0 unless way 1 hits

  always_comb begin
    state_nxt = state;
    dhit      = 1'b0;
    flushed   = 1'b0;
    mem_ren   = 1'b0;
    mem_wen   = 1'b0;
    mem_addr  = '0;
    mem_store = '0;
    acc_hit   = 1'b0;
    wr_hit    = 1'b0;
    fill_we   = 1'b0;
    fill_last = 1'b0;
    fl_start  = 1'b0;
    fl_adv    = 1'b0;

    case (state)
      cache_pkg::IDLE: begin
        if (req) begin
          if (hit0 || hit1) begin
            dhit    = 1'b1;
            acc_hit = 1'b1;
            wr_hit  = dmemwen;
          end else if (victim_dirty) begin
            state_nxt = cache_pkg::EVICT0;
          end else begin
            state_nxt = cache_pkg::FETCH0;
          end
        end else if (halt) begin
          fl_start  = 1'b1;
          state_nxt = cache_pkg::FLUSH_SCAN;
        end
      end

      cache_pkg::FETCH0, cache_pkg::FETCH1: begin
        mem_ren  = 1'b1;
        mem_addr = {dmemaddr[cache_pkg::WORD_W-1:3], fetch_word, 2'b00};
        if (!mem_wait) begin
          fill_we   = 1'b1;
          fill_last = fetch_word;
          state_nxt = fetch_word ? cache_pkg::IDLE : cache_pkg::FETCH1;
        end
      end

      // eviction and flush write-back share one datapath
      cache_pkg::EVICT0, cache_pkg::EVICT1, cache_pkg::FLUSH_WB0, cache_pkg::FLUSH_WB1: begin
        mem_wen   = 1'b1;
        mem_addr  = {tags[wb_way][wb_idx], wb_idx, wb_word, 2'b00};
        mem_store = data[wb_way][wb_idx][wb_word];
        if (!mem_wait) begin
          case (state)
            cache_pkg::EVICT0:    state_nxt = cache_pkg::EVICT1;
            cache_pkg::EVICT1:    state_nxt = cache_pkg::FETCH0;
            cache_pkg::FLUSH_WB0: state_nxt = cache_pkg::FLUSH_WB1;
            default: begin
              fl_adv    = 1'b1;
              state_nxt = scan_last ? cache_pkg::FLUSHED : cache_pkg::FLUSH_SCAN;
            end
          endcase
        end
      end

      cache_pkg::FLUSH_SCAN: begin
        if (line_dirty) begin
          state_nxt = cache_pkg::FLUSH_WB0;
        end else begin
          fl_adv    = 1'b1;  // clean or invalid line, just drop it
          state_nxt = scan_last ? cache_pkg::FLUSHED : cache_pkg::FLUSH_SCAN;
        end
      end

      cache_pkg::FLUSHED: begin
        flushed = 1'b1;
        if (!halt) state_nxt = cache_pkg::IDLE;
      end

      default: state_nxt = cache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= cache_pkg::IDLE;
      count    <= '0;
      fl_way   <= 1'b0;
      valid[0] <= '0;
      valid[1] <= '0;
      dirty[0] <= '0;
      dirty[1] <= '0;
      lru      <= '0;
    end else begin
      state <= state_nxt;
      if (acc_hit) lru[req_idx] <= ~hit1;  // point at the other way
      if (wr_hit) dirty[hit1][req_idx] <= 1'b1;
      if (fill_last) begin
        valid[victim][req_idx] <= 1'b1;
        dirty[victim][req_idx] <= 1'b0;
      end
      if (fl_start) begin
        count  <= '0;
        fl_way <= 1'b0;
      end
      if (fl_adv) begin
        valid[fl_way][count] <= 1'b0;
        dirty[fl_way][count] <= 1'b0;
        count <= set_last ? '0 : count + 1'b1;
        if (set_last) fl_way <= ~fl_way;
      end
    end
  end

  // tags and data words
  always_ff @(posedge CLK) begin
    if (wr_hit) data[hit1][req_idx][req_off] <= dmemstore;
    if (fill_we) data[victim][req_idx][fetch_word] <= mem_load;
    if (fill_last) tags[victim][req_idx] <= req_tag;  // tag goes in with the last word
  end

endmodule

//--- rtl/dcache_top.sv
// data cache subsystem with the cache controller and its wait-state RAM
`timescale 1ns/100ps

module dcache_top (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        dmemren,
  input  logic                        dmemwen,
  input  logic                        halt,
  input  logic [cache_pkg::WORD_W-1:0] dmemaddr,
  input  logic [cache_pkg::WORD_W-1:0] dmemstore,
  output logic [cache_pkg::WORD_W-1:0] dmemload,
  output logic                        dhit,
  output logic                        flushed
);

  // cache to RAM
  logic                         mem_ren;
  logic                         mem_wen;
  logic [cache_pkg::WORD_W-1:0] mem_addr;
  logic [cache_pkg::WORD_W-1:0] mem_store;
  logic [cache_pkg::WORD_W-1:0] mem_load;
  logic                         mem_wait;

  dcache u_dcache (
    .CLK(CLK), .nRST(nRST),
    .dmemren(dmemren), .dmemwen(dmemwen), .halt(halt),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore),
    .dmemload(dmemload), .dhit(dhit), .flushed(flushed),
    .mem_ren(mem_ren), .mem_wen(mem_wen),
    .mem_addr(mem_addr), .mem_store(mem_store),
    .mem_load(mem_load), .mem_wait(mem_wait)
  );

  ram_ctrl u_ram (
    .CLK(CLK), .nRST(nRST),
    .mem_ren(mem_ren), .mem_wen(mem_wen),
    .mem_addr(mem_addr), .mem_store(mem_store),
    .mem_load(mem_load), .mem_wait(mem_wait)
  );

endmodule

//--- dv/dcache_asserts.sv
// concurrent protocol assertions for the cache controller
`timescale 1ns/100ps

module dcache_asserts (
  input logic                         CLK,
  input logic                         nRST,
  input logic                         mem_ren,
  input logic                         mem_wen,
  input logic                         mem_wait,
  input logic [cache_pkg::WORD_W-1:0] mem_addr,
  input logic                         dhit,
  input logic                         flushed
);

  int fail_count = 0;  // read by the testbench

  mem_excl: assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
    else begin
      fail_count++;
      $error("mem_ren and mem_wen high in the same cycle");
    end

  hit_flush_excl: assert property (@(posedge CLK) disable iff (!nRST) !(dhit && flushed))
    else begin
      fail_count++;
      $error("dhit and flushed high in the same cycle");
    end

  // address must not move while the RAM stalls the access
  addr_hold: assert property (@(posedge CLK) disable iff (!nRST)
                              (mem_ren || mem_wen) && mem_wait |=> $stable(mem_addr))
    else begin
      fail_count++;
      $error("mem_addr changed while mem_wait was high");
    end

endmodule

//--- dv/tb_clkgen.sv
// testbench clock and reset generator
`timescale 1ns/100ps

module tb_clkgen (
  output logic CLK,
  output logic nRST
);

  localparam int HALF_NS = 20;  // 40 ns period

  initial begin
    CLK = 1'b0;
    forever #HALF_NS CLK = ~CLK;
  end

  initial begin
    nRST = 1'b0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;  // release away from the active edge
  end

endmodule

//--- dv/dcache_tb.sv
// testbench for the data cache subsystem with stimulus table, shadow memory and watchdog
`timescale 1ns/100ps

module dcache_tb;

  localparam int CLK_NS      = 40;
  localparam int DRIVE_NS    = 2;  // input skew after the rising edge
  localparam int NROWS       = 32;
  localparam int WATCHDOG_NS = (NROWS * 40 + 8) * CLK_NS;  // 40 cycles a row, plus reset

  localparam logic [1:0] OP_RD   = 2'd0;
  localparam logic [1:0] OP_WR   = 2'd1;
  localparam logic [1:0] OP_HALT = 2'd2;

  // first-cycle expectation for dhit
  localparam logic [1:0] LAT_ANY  = 2'd0;
  localparam logic [1:0] LAT_HIT  = 2'd1;
  localparam logic [1:0] LAT_MISS = 2'd2;

  typedef struct packed {
    logic [1:0] op;
    logic [1:0] lat;
    logic [7:0] addr;
  } row_t;

  localparam row_t ROWS [NROWS] = '{
    '{OP_RD,   LAT_MISS, 8'h00},  // cold miss, then hit
    '{OP_RD,   LAT_HIT,  8'h00},
    '{OP_WR,   LAT_HIT,  8'h04},  // write hit to the other word
    '{OP_RD,   LAT_HIT,  8'h04},
    '{OP_WR,   LAT_MISS, 8'h10},  // write allocate in set 2
    '{OP_RD,   LAT_HIT,  8'h10},
    '{OP_RD,   LAT_HIT,  8'h14},  // neighbour keeps fill value
    '{OP_RD,   LAT_MISS, 8'h50},  // second way of set 2
    '{OP_RD,   LAT_HIT,  8'h10},
    '{OP_RD,   LAT_HIT,  8'h50},
    '{OP_RD,   LAT_MISS, 8'h90},  // evicts dirty 0x10
    '{OP_RD,   LAT_MISS, 8'h10},
    '{OP_RD,   LAT_HIT,  8'h90},
    '{OP_WR,   LAT_MISS, 8'h28},  // three writers in set 5
    '{OP_WR,   LAT_MISS, 8'h68},
    '{OP_WR,   LAT_MISS, 8'hA8},
    '{OP_RD,   LAT_MISS, 8'h28},
    '{OP_RD,   LAT_MISS, 8'h68},
    '{OP_RD,   LAT_MISS, 8'hA8},
    '{OP_WR,   LAT_MISS, 8'h30},
    '{OP_WR,   LAT_MISS, 8'h3C},
    '{OP_HALT, LAT_ANY,  8'h00},
    '{OP_RD,   LAT_MISS, 8'h30},  // everything misses after the flush
    '{OP_RD,   LAT_HIT,  8'h34},
    '{OP_RD,   LAT_MISS, 8'h3C},
    '{OP_RD,   LAT_MISS, 8'h04},
    '{OP_RD,   LAT_MISS, 8'h68},
    '{OP_RD,   LAT_MISS, 8'hA8},
    '{OP_RD,   LAT_MISS, 8'h90},
    '{OP_RD,   LAT_MISS, 8'hC0},  // never written
    '{OP_RD,   LAT_MISS, 8'h10},
    '{OP_RD,   LAT_MISS, 8'h28}
  };

  logic        CLK;
  logic        nRST;
  logic        dmemren;
  logic        dmemwen;
  logic        halt;
  logic [31:0] dmemaddr;
  logic [31:0] dmemstore;
  logic [31:0] dmemload;
  logic        dhit;
  logic        flushed;

  logic [31:0] shadow [cache_pkg::RAM_WORDS];  // expected RAM and cache contents
  logic [31:0] rng;

  tb_clkgen u_clk (.CLK(CLK), .nRST(nRST));

  dcache_top DUT (
    .CLK(CLK), .nRST(nRST),
    .dmemren(dmemren), .dmemwen(dmemwen), .halt(halt),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore),
    .dmemload(dmemload), .dhit(dhit), .flushed(flushed)
  );

  bind dcache dcache_asserts u_asserts (
    .CLK(CLK), .nRST(nRST),
    .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_wait(mem_wait), .mem_addr(mem_addr),
    .dhit(dhit), .flushed(flushed)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic check_asserts(input int n);
    if (DUT.u_dcache.u_asserts.fail_count != 0) begin
      $display("A protocol assertion in the cache failed while row %0d was running", n);
      $display("ERRORS FOUND");
      $fatal(1, "stopping after an assertion failure");
    end
  endtask

  task automatic run_row(input int n);
    row_t       r;
    logic       first;
    logic [5:0] widx;
    r    = ROWS[n];
    widx = r.addr[7:2];
    dmemaddr = {24'h0, r.addr};
    case (r.op)
      OP_RD: dmemren = 1'b1;
      OP_WR: begin
        rng       = xorshift32(rng);
        dmemstore = rng;
        dmemwen   = 1'b1;
      end
      default: halt = 1'b1;
    endcase
    @(negedge CLK);
    first = dhit;
    if (r.op == OP_HALT) begin
      while (!flushed) @(negedge CLK);
    end else begin
      while (!dhit) @(negedge CLK);
      if (r.lat == LAT_HIT) check("dhit in first cycle", {31'd0, first}, 32'd1);
      if (r.lat == LAT_MISS) check("dhit in first cycle", {31'd0, first}, 32'd0);
      if (r.op == OP_RD) check("dmemload", dmemload, shadow[widx]);
      else shadow[widx] = dmemstore;  // write lands at the coming edge
    end
    @(posedge CLK);
    #DRIVE_NS;
    dmemren = 1'b0;
    dmemwen = 1'b0;
    halt    = 1'b0;
  endtask

  initial begin
    dmemren   = 1'b0;
    dmemwen   = 1'b0;
    halt      = 1'b0;
    dmemaddr  = '0;
    dmemstore = '0;
    rng       = 32'd69;
    for (int i = 0; i < cache_pkg::RAM_WORDS; i++) begin
      shadow[i] = (32'(i) << 2) ^ cache_pkg::FILL_KEY;  // byte address xor key
    end
    @(posedge nRST);
    @(negedge CLK);
    check("dhit", {31'd0, dhit}, 32'd0);
    check("flushed", {31'd0, flushed}, 32'd0);
    @(posedge CLK);
    #DRIVE_NS;
    for (int n = 0; n < NROWS; n++) begin
      run_row(n);
      check_asserts(n);
    end
    if (DUT.u_dcache.u_asserts.fail_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("ERRORS FOUND");
      $fatal(1, "assertion failures were counted");
    end
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: a cache request or flush never completed within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- sim.f
rtl/cache_pkg.sv
rtl/ram_ctrl.sv
rtl/dcache.sv
rtl/dcache_top.sv
dv/dcache_asserts.sv
dv/tb_clkgen.sv
dv/dcache_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the data cache testbench

VERILATOR := verilator
TOP       := dcache_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
RUN_ARGS  := +verilator+error+limit+100
PASS_MSG  := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the pipeline status is the grep, so a missing pass message fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
